/* include/conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// pixel and weight width, signed
`define CONV_PIX_W      8

// accumulator and result width, signed
`define CONV_ACC_W      24

// square image side
`define CONV_IMG_SIZE   4

`define CONV_NUM_CH     3
`define CONV_NUM_KER    4

// 3x3 window
`define CONV_TAPS       9

// fifo entries, also the producer's starting credit count
`define CONV_FIFO_DEPTH 4

`endif

/* hdl/conv_pkg.sv */
`default_nettype none

`include "conv_defs.svh"

package conv_pkg;

	typedef logic signed [`CONV_PIX_W-1:0] pix_t;
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	// zero_pad: 1 zero padding, 0 replicate
	// leaky:    1 leaky relu, 0 plain relu
	typedef struct packed {
		logic zero_pad;
		logic leaky;
	} conv_mode_t;

	// channel, row, column
	typedef pix_t [`CONV_NUM_CH-1:0][`CONV_IMG_SIZE-1:0][`CONV_IMG_SIZE-1:0] image_t;

	// channel, kernel-major tap index
	typedef pix_t [`CONV_NUM_CH-1:0][`CONV_NUM_KER*`CONV_TAPS-1:0] kernel_bank_t;

	// one padded window plus the weights of its kernel
	typedef struct packed {
		pix_t [`CONV_NUM_CH-1:0][`CONV_TAPS-1:0] pix;
		pix_t [`CONV_NUM_CH-1:0][`CONV_TAPS-1:0] wgt;
		conv_mode_t                              mode;
	} window_item_t;

endpackage

`default_nettype wire

/* hdl/frame_loader.sv */
`default_nettype none

`include "conv_defs.svh"

module frame_loader (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       mode_valid,
	input  wire conv_pkg::conv_mode_t mode,
	input  wire                       img_valid,
	input  wire                       ker_valid,
	input  wire conv_pkg::pix_t       image_1,
	input  wire conv_pkg::pix_t       image_2,
	input  wire conv_pkg::pix_t       image_3,
	input  wire conv_pkg::pix_t       kernel_1,
	input  wire conv_pkg::pix_t       kernel_2,
	input  wire conv_pkg::pix_t       kernel_3,
	output conv_pkg::conv_mode_t      frame_mode,
	output conv_pkg::image_t          image,
	output conv_pkg::kernel_bank_t    kernels,
	output logic                      start
);

	localparam int POS_W    = $clog2(`CONV_IMG_SIZE);
	localparam int KER_TAPS = `CONV_NUM_KER * `CONV_TAPS;
	localparam int KIDX_W   = $clog2(KER_TAPS);

	logic [POS_W-1:0]                  img_row;
	logic [POS_W-1:0]                  img_col;
	logic [KIDX_W-1:0]                 ker_idx;
	conv_pkg::pix_t [`CONV_NUM_CH-1:0] img_beat;
	conv_pkg::pix_t [`CONV_NUM_CH-1:0] ker_beat;

	assign img_beat = {image_3, image_2, image_1};
	assign ker_beat = {kernel_3, kernel_2, kernel_1};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_mode <= '0;
		end else if (mode_valid) begin
			frame_mode <= mode;
		end
	end

	// ------------------------------
	// image raster position
	// ------------------------------
	// restarts whenever the image burst ends
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			img_row <= '0;
			img_col <= '0;
		end else if (img_valid) begin
			if (img_col == POS_W'(`CONV_IMG_SIZE - 1)) begin
				img_col <= '0;
				img_row <= img_row + 1'b1;
			end else begin
				img_col <= img_col + 1'b1;
			end
		end else begin
			img_row <= '0;
			img_col <= '0;
		end
	end

	// ------------------------------
	// kernel tap index and start
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ker_idx <= '0;
			start   <= 1'b0;
		end else begin
			start <= 1'b0;
			if (ker_valid) begin
				if (ker_idx == KIDX_W'(KER_TAPS - 1)) begin
					// last tap of the last kernel
					ker_idx <= '0;
					start   <= 1'b1;
				end else begin
					ker_idx <= ker_idx + 1'b1;
				end
			end
		end
	end

	// pixel and weight stores
	always_ff @(posedge clk) begin
		for (int ch = 0; ch < `CONV_NUM_CH; ch++) begin
			if (img_valid) begin
				image[ch][img_row][img_col] <= img_beat[ch];
			end
			if (ker_valid) begin
				kernels[ch][ker_idx] <= ker_beat[ch];
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/window_gen.sv */
`default_nettype none

`include "conv_defs.svh"

module window_gen (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         start,
	input  wire conv_pkg::conv_mode_t   frame_mode,
	input  wire conv_pkg::image_t       image,
	input  wire conv_pkg::kernel_bank_t kernels,
	output logic                        push,
	output conv_pkg::window_item_t      item,
	input  wire                         credit_ret
);

	localparam int IMG    = `CONV_IMG_SIZE;
	localparam int KSIDE  = 3;
	localparam int POS_W  = $clog2(IMG);
	localparam int KER_W  = $clog2(`CONV_NUM_KER);
	localparam int KIDX_W = $clog2(`CONV_NUM_KER * `CONV_TAPS);
	localparam int CRED_W = $clog2(`CONV_FIFO_DEPTH + 1);

	logic              busy;
	logic [KER_W-1:0]  ker_cnt;
	logic [POS_W-1:0]  row;
	logic [POS_W-1:0]  col;
	logic [CRED_W-1:0] credits;

	// replicate padding pulls the index back onto the edge
	function automatic logic [POS_W-1:0] clamp_pos(input int p);
		if (p < 0) begin
			return '0;
		end
		if (p > IMG - 1) begin
			return POS_W'(IMG - 1);
		end
		return POS_W'(p);
	endfunction

	assign push = busy && (credits != '0);

	// ------------------------------
	// position walk, kernel-major
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			ker_cnt <= '0;
			row     <= '0;
			col     <= '0;
		end else if (start) begin
			busy    <= 1'b1;
			ker_cnt <= '0;
			row     <= '0;
			col     <= '0;
		end else if (push) begin
			if (col == POS_W'(IMG - 1)) begin
				col <= '0;
				if (row == POS_W'(IMG - 1)) begin
					row <= '0;
					if (ker_cnt == KER_W'(`CONV_NUM_KER - 1)) begin
						// 64th window sent
						ker_cnt <= '0;
						busy    <= 1'b0;
					end else begin
						ker_cnt <= ker_cnt + 1'b1;
					end
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// one credit per free fifo slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CRED_W'(`CONV_FIFO_DEPTH);
		end else begin
			case ({push, credit_ret})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// ------------------------------
	// window gather
	// ------------------------------
	always_comb begin : gather
		int   r;
		int   c;
		logic off_img;
		logic [KIDX_W-1:0] kidx;
		item = '0;
		for (int ch = 0; ch < `CONV_NUM_CH; ch++) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				r = int'(row) + t / KSIDE - 1;
				c = int'(col) + t % KSIDE - 1;
				off_img = (r < 0) || (r >= IMG) || (c < 0) || (c >= IMG);
				kidx = KIDX_W'(int'(ker_cnt) * `CONV_TAPS + t);
				if (off_img && frame_mode.zero_pad) begin
					item.pix[ch][t] = '0;
				end else begin
					item.pix[ch][t] = image[ch][clamp_pos(r)][clamp_pos(c)];
				end
				item.wgt[ch][t] = kernels[ch][kidx];
			end
		end
		item.mode = frame_mode;
	end

endmodule

`default_nettype wire

/* hdl/window_fifo.sv */
`default_nettype none

`include "conv_defs.svh"

module window_fifo (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          push,
	input  wire conv_pkg::window_item_t  item,
	output logic                         head_valid,
	output conv_pkg::window_item_t       head,
	input  wire                          pop,
	output logic                         credit_ret
);

	localparam int DEPTH = `CONV_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	conv_pkg::window_item_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign head_valid = (count != '0);
	assign head       = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= item;
		end
	end

	// ------------------------------
	// pointers and fill level
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// freed slot goes back to the producer a cycle later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_ret <= 1'b0;
		end else begin
			credit_ret <= pop;
		end
	end

endmodule

`default_nettype wire

/* hdl/conv_mac.sv */
`default_nettype none

`include "conv_defs.svh"

module conv_mac (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         head_valid,
	input  wire conv_pkg::window_item_t head,
	output logic                        pop,
	output logic                        out_valid,
	output conv_pkg::acc_t              out
);

	localparam int PH_W = $clog2(`CONV_NUM_CH);

	logic [PH_W-1:0]                   phase;
	logic                              act_go;
	conv_pkg::window_item_t            item_q;
	conv_pkg::acc_t                    acc;
	conv_pkg::acc_t                    ch_sum;
	conv_pkg::acc_t                    act_val;
	conv_pkg::pix_t [`CONV_TAPS-1:0]   sel_pix;
	conv_pkg::pix_t [`CONV_TAPS-1:0]   sel_wgt;

	function automatic conv_pkg::acc_t dot_taps(
		input conv_pkg::pix_t [`CONV_TAPS-1:0] p,
		input conv_pkg::pix_t [`CONV_TAPS-1:0] w
	);
		conv_pkg::acc_t s;
		s = '0;
		for (int t = 0; t < `CONV_TAPS; t++) begin
			s = s + conv_pkg::acc_t'(p[t]) * conv_pkg::acc_t'(w[t]);
		end
		return s;
	endfunction

	// new item only when the accumulator is free
	assign pop = head_valid && (phase == '0);

	// ------------------------------
	// channel select and accumulate
	// ------------------------------
	// channel 0 comes straight off the fifo head on the pop cycle
	always_comb begin
		if (phase == '0) begin
			sel_pix = head.pix[0];
			sel_wgt = head.wgt[0];
		end else begin
			sel_pix = item_q.pix[phase];
			sel_wgt = item_q.wgt[phase];
		end
	end

	assign ch_sum = dot_taps(sel_pix, sel_wgt);

	always_ff @(posedge clk) begin
		if (pop) begin
			item_q <= head;
			acc    <= ch_sum;
		end else if (phase != '0) begin
			acc <= acc + ch_sum;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase     <= '0;
			act_go    <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			act_go    <= (phase == PH_W'(`CONV_NUM_CH - 1));
			out_valid <= act_go;
			if (pop) begin
				phase <= PH_W'(1);
			end else if (phase == PH_W'(`CONV_NUM_CH - 1)) begin
				phase <= '0;
			end else if (phase != '0) begin
				phase <= phase + 1'b1;
			end
		end
	end

	// ------------------------------
	// activation
	// ------------------------------
	// mode is still the finished item's while a new pop overwrites item_q
	always_comb begin
		if (!acc[`CONV_ACC_W-1]) begin
			act_val = acc;
		end else if (item_q.mode.leaky) begin
			act_val = acc >>> 3;
		end else begin
			act_val = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (act_go) begin
			out <= act_val;
		end
	end

endmodule

`default_nettype wire

/* hdl/conv_top.sv */
`default_nettype none

module conv_top (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       mode_valid,
	input  wire conv_pkg::conv_mode_t mode,
	input  wire                       img_valid,
	input  wire conv_pkg::pix_t       image_1,
	input  wire conv_pkg::pix_t       image_2,
	input  wire conv_pkg::pix_t       image_3,
	input  wire                       ker_valid,
	input  wire conv_pkg::pix_t       kernel_1,
	input  wire conv_pkg::pix_t       kernel_2,
	input  wire conv_pkg::pix_t       kernel_3,
	output logic                      out_valid,
	output conv_pkg::acc_t            out
);

	// loader to producer
	conv_pkg::conv_mode_t   frame_mode;
	conv_pkg::image_t       image;
	conv_pkg::kernel_bank_t kernels;
	logic                   start;

	// producer to fifo
	logic                   push;
	conv_pkg::window_item_t item;
	logic                   credit_ret;

	// fifo to mac
	logic                   head_valid;
	conv_pkg::window_item_t head;
	logic                   pop;

	frame_loader loader_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode_valid (mode_valid),
		.mode       (mode),
		.img_valid  (img_valid),
		.ker_valid  (ker_valid),
		.image_1    (image_1),
		.image_2    (image_2),
		.image_3    (image_3),
		.kernel_1   (kernel_1),
		.kernel_2   (kernel_2),
		.kernel_3   (kernel_3),
		.frame_mode (frame_mode),
		.image      (image),
		.kernels    (kernels),
		.start      (start)
	);

	window_gen gen_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.frame_mode (frame_mode),
		.image      (image),
		.kernels    (kernels),
		.push       (push),
		.item       (item),
		.credit_ret (credit_ret)
	);

	window_fifo fifo_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (push),
		.item       (item),
		.head_valid (head_valid),
		.head       (head),
		.pop        (pop),
		.credit_ret (credit_ret)
	);

	conv_mac mac_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.head_valid (head_valid),
		.head       (head),
		.pop        (pop),
		.out_valid  (out_valid),
		.out        (out)
	);

endmodule

`default_nettype wire

/* verif/conv_tb.sv */
`default_nettype none

`include "conv_defs.svh"

module conv_tb;

	localparam int NUM_FRAMES = 3;
	localparam int IMG_BEATS  = `CONV_IMG_SIZE * `CONV_IMG_SIZE;
	localparam int KER_BEATS  = `CONV_NUM_KER * `CONV_TAPS;
	localparam int RESULTS    = `CONV_NUM_KER * IMG_BEATS;
	localparam int TIMEOUT    = 2000;

	logic                 clk;
	logic                 rst_n;
	logic                 mode_valid;
	conv_pkg::conv_mode_t mode;
	logic                 img_valid;
	conv_pkg::pix_t       image_1;
	conv_pkg::pix_t       image_2;
	conv_pkg::pix_t       image_3;
	logic                 ker_valid;
	conv_pkg::pix_t       kernel_1;
	conv_pkg::pix_t       kernel_2;
	conv_pkg::pix_t       kernel_3;
	logic                 out_valid;
	conv_pkg::acc_t       out;

	// trace contents, flattened in file order
	int mode_arr [NUM_FRAMES];
	int img_flat [NUM_FRAMES * IMG_BEATS * `CONV_NUM_CH];
	int ker_flat [NUM_FRAMES * KER_BEATS * `CONV_NUM_CH];
	int exp_flat [NUM_FRAMES * RESULTS];
	int got_cnt;

	conv_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode_valid (mode_valid),
		.mode       (mode),
		.img_valid  (img_valid),
		.image_1    (image_1),
		.image_2    (image_2),
		.image_3    (image_3),
		.ker_valid  (ker_valid),
		.kernel_1   (kernel_1),
		.kernel_2   (kernel_2),
		.kernel_3   (kernel_3),
		.out_valid  (out_valid),
		.out        (out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input longint actual, input longint expected);
		if (actual != expected) begin
			$display("FAILED time=%0t %s got %0d expected %0d", $time, name, actual, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic read_trace();
		int  fd;
		int  code;
		int  v;
		int  m_cnt;
		int  i_cnt;
		int  k_cnt;
		int  e_cnt;
		byte tag;
		string line;
		m_cnt = 0;
		i_cnt = 0;
		k_cnt = 0;
		e_cnt = 0;
		fd = $fopen("verif/conv_trace.txt", "r");
		if (fd == 0) begin
			fail_run("cannot open the trace file verif/conv_trace.txt");
		end
		while ($fscanf(fd, " %c", tag) == 1) begin
			if (tag == "#") begin
				void'($fgets(line, fd));
			end else if (tag == "M") begin
				code = $fscanf(fd, "%d", v);
				if (code != 1) begin
					fail_run("trace file has a missing or malformed number");
				end
				mode_arr[m_cnt] = v;
				m_cnt++;
			end else if (tag == "I") begin
				for (int n = 0; n < 4 * `CONV_NUM_CH; n++) begin
					code = $fscanf(fd, "%d", v);
					if (code != 1) begin
						fail_run("trace file has a missing or malformed number");
					end
					img_flat[i_cnt * 4 * `CONV_NUM_CH + n] = v;
				end
				i_cnt++;
			end else if (tag == "K") begin
				for (int n = 0; n < `CONV_TAPS * `CONV_NUM_CH; n++) begin
					code = $fscanf(fd, "%d", v);
					if (code != 1) begin
						fail_run("trace file has a missing or malformed number");
					end
					ker_flat[k_cnt * `CONV_TAPS * `CONV_NUM_CH + n] = v;
				end
				k_cnt++;
			end else if (tag == "E") begin
				for (int n = 0; n < IMG_BEATS; n++) begin
					code = $fscanf(fd, "%d", v);
					if (code != 1) begin
						fail_run("trace file has a missing or malformed number");
					end
					exp_flat[e_cnt * IMG_BEATS + n] = v;
				end
				e_cnt++;
			end else begin
				fail_run("unknown line tag in the trace file");
			end
		end
		$fclose(fd);
		if (m_cnt != NUM_FRAMES || i_cnt != 4 * NUM_FRAMES || k_cnt != 4 * NUM_FRAMES ||
			e_cnt != 4 * NUM_FRAMES) begin
			fail_run("trace file does not hold three complete frames");
		end
	endtask

	// inputs change just after the rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_gap();
		int n;
		n = $urandom % 4;
		repeat (n) tick();
	endtask

	task automatic drive_frame(input int f);
		int base;
		idle_gap();
		mode_valid = 1'b1;
		mode       = conv_pkg::conv_mode_t'(mode_arr[f][1:0]);
		tick();
		mode_valid = 1'b0;
		idle_gap();
		// image beats must be back to back
		for (int b = 0; b < IMG_BEATS; b++) begin
			base      = (f * IMG_BEATS + b) * `CONV_NUM_CH;
			img_valid = 1'b1;
			image_1   = conv_pkg::pix_t'(img_flat[base]);
			image_2   = conv_pkg::pix_t'(img_flat[base + 1]);
			image_3   = conv_pkg::pix_t'(img_flat[base + 2]);
			tick();
		end
		img_valid = 1'b0;
		idle_gap();
		for (int b = 0; b < KER_BEATS; b++) begin
			base      = (f * KER_BEATS + b) * `CONV_NUM_CH;
			ker_valid = 1'b1;
			kernel_1  = conv_pkg::pix_t'(ker_flat[base]);
			kernel_2  = conv_pkg::pix_t'(ker_flat[base + 1]);
			kernel_3  = conv_pkg::pix_t'(ker_flat[base + 2]);
			tick();
		end
		ker_valid = 1'b0;
	endtask

	task automatic wait_results(input int target);
		int cycles;
		cycles = 0;
		while (got_cnt < target) begin
			tick();
			cycles++;
			if (cycles > TIMEOUT) begin
				fail_run("timed out waiting for the results of a frame");
			end
		end
	endtask

	// ------------------------------
	// result collector
	// ------------------------------
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			if (got_cnt >= NUM_FRAMES * RESULTS) begin
				fail_run("a result arrived after all expected results");
			end else begin
				check_value("out", out, exp_flat[got_cnt]);
				got_cnt++;
			end
		end
	end

	initial begin
		mode_valid = 1'b0;
		mode       = '0;
		img_valid  = 1'b0;
		image_1    = '0;
		image_2    = '0;
		image_3    = '0;
		ker_valid  = 1'b0;
		kernel_1   = '0;
		kernel_2   = '0;
		kernel_3   = '0;
		rst_n      = 1'b0;
		got_cnt    = 0;
		void'($urandom(32'hcc14));
		read_trace();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// quiet outputs before any frame
		for (int i = 0; i < 10; i++) begin
			tick();
			check_value("out_valid", out_valid, 0);
		end

		for (int f = 0; f < NUM_FRAMES; f++) begin
			drive_frame(f);
			wait_results((f + 1) * RESULTS);
		end

		// a repeated result would show up here
		repeat (50) tick();

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* conv_top.f */
+incdir+include
hdl/conv_pkg.sv
hdl/frame_loader.sv
hdl/window_gen.sv
hdl/window_fifo.sv
hdl/conv_mac.sv
hdl/conv_top.sv
verif/conv_tb.sv

/* Makefile */
TOOL       := verilator
TOP        := conv_tb
FLIST      := conv_top.f
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD      := obj_dir
LOG        := sim.log
PASS_TEXT  := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* verif/conv_trace.txt */
# M mode (bit1 zero_pad, bit0 leaky) / I one image row: 4 pixels of ch1 ch2 ch3
# K one kernel: 9 taps of ch1 ch2 ch3 / E one kernel's 16 expected results, raster
M 0
I 1 2 0 2 2 1 3 2 2 4 2 3
I 5 2 10 6 2 11 7 2 12 8 2 13
I 9 2 20 10 2 21 11 2 22 12 2 23
I 13 2 30 14 2 31 15 2 32 16 2 33
K 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
K 0 1 0 0 1 0 0 1 0 0 1 0 1 1 0 0 1 0 0 1 0 0 1 0 0 1 0
K 0 0 0 0 0 0 0 0 0 0 0 0 -1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
K 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 16
E 19 20 21 22 23 24 25 26 27 28 29 30 31 32 33 34
E 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
E 0 0 1 2 0 0 1 2 10 10 11 12 20 20 21 22
M 3
I 8 1 1 8 2 2 8 3 3 8 4 4
I 8 5 5 8 6 6 8 7 7 8 8 8
I 8 9 9 8 10 10 8 11 11 8 12 12
I 8 13 13 8 14 14 8 15 15 8 16 16
K 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0
K -1 0 0 -1 0 0 -1 0 0 -1 0 0 -1 0 0 -1 0 0 -1 0 0 -1 0 0 -1 0 0
K 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0
K 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -3 0 0 0 0 0 0 0 0 0 0 0 0
E 32 48 48 32 48 72 72 48 48 72 72 48 32 48 48 32
E -4 -6 -6 -4 -6 -9 -9 -6 -6 -9 -9 -6 -4 -6 -6 -4
E 6 7 8 0 10 11 12 0 14 15 16 0 0 0 0 0
E -1 -1 -2 -2 -2 -3 -3 -3 -4 -4 -5 -5 -5 -6 -6 -6
M 1
I 2 -1 0 2 -2 0 2 -3 0 2 -4 0
I 2 -5 0 2 -6 0 2 -7 0 2 -8 0
I 2 -9 0 2 -10 0 2 -11 0 2 -12 0
I 2 -13 0 2 -14 0 2 -15 0 2 -16 0
K 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0 1 0 0
K 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
K 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
K 1 0 0 1 0 0 1 0 0 1 0 0 1 1 0 1 0 0 1 0 0 1 0 0 1 0 0
E 18 18 18 18 18 18 18 18 18 18 18 18 18 18 18 18
E -1 -1 -1 -1 -1 -1 -1 -1 -2 -2 -2 -2 -2 -2 -2 -2
E -1 -1 -1 -1 -1 -1 -1 -1 -2 -2 -2 -2 -3 -3 -3 -3
E 17 16 15 14 13 12 11 10 9 8 7 6 5 4 3 2
